//--- logic/cce_cache_pkg.sv
// shared widths, vector types, opcode and message enums and cache geometry for the bridge
package cce_cache_pkg;

  // bus widths
  localparam int PADDR_W = 32;
  localparam int CADDR_W = 28;
  localparam int DATA_W = 64;
  localparam int BYTE_W = 8;
  localparam int MASK_W = DATA_W / BYTE_W;
  localparam int BYTE_OFF_W = $clog2(MASK_W);

  // cache geometry
  localparam int BLOCK_WORDS = 8;
  localparam int BLOCK_OFF_W = BYTE_OFF_W + $clog2(BLOCK_WORDS);
  localparam int L2_SETS = 16;
  localparam int L2_WAYS = 2;
  localparam int TAG_TOTAL = L2_SETS * L2_WAYS;
  localparam int TAG_IDX_W = $clog2(TAG_TOTAL);
  // one extra bit so the counter can reach TAG_TOTAL
  localparam int TAG_CNT_W = TAG_IDX_W + 1;

  // response header queue
  localparam int RESP_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(RESP_FIFO_DEPTH);
  localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [CADDR_W-1:0] caddr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [MASK_W-1:0] mask_t;
  typedef logic [BYTE_OFF_W-1:0] byte_off_t;
  typedef logic [TAG_CNT_W-1:0] tag_cnt_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  // byte count is 1 << size
  typedef logic [1:0] msg_size_t;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } msg_type_e;

  typedef enum logic [3:0] {
    LB    = 4'h0,
    LH    = 4'h1,
    LW    = 4'h2,
    LD    = 4'h3,
    SB    = 4'h4,
    SH    = 4'h5,
    SW    = 4'h6,
    SD    = 4'h7,
    TAGST = 4'h8
  } cache_opcode_e;

  typedef struct packed {
    msg_type_e msg_type;
    msg_size_t size;
    paddr_t    addr;
  } mem_hdr_t;

endpackage

//--- logic/cache_req_if.sv
// one cache request channel with valid/ready, shared by the tag clear and command paths
interface cache_req_if
  import cce_cache_pkg::*;
();

  cache_opcode_e opcode;
  caddr_t        addr;
  data_t         data;
  mask_t         mask;
  logic          v;
  logic          ready;

  // requester side
  modport master (
    output opcode, addr, data, mask, v,
    input  ready
  );

  // side that forwards the request to the cache
  modport slave (
    input  opcode, addr, data, mask, v,
    output ready
  );

endinterface

//--- logic/cache_tag_init.sv
// issues one tag store per set and way after start and reports when all are acknowledged
module cache_tag_init
  import cce_cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        start_i,
  input  logic        ack_i,
  cache_req_if.master tag_o,
  output logic        done_o
);

  tag_cnt_t sent_r;
  tag_cnt_t acked_r;
  logic     sent_all;
  logic     acked_all;

  assign sent_all = (sent_r == tag_cnt_t'(TAG_TOTAL));
  assign acked_all = (acked_r == tag_cnt_t'(TAG_TOTAL));

  // set and way index sits just above the block offset
  assign tag_o.opcode = TAGST;
  assign tag_o.addr = caddr_t'({sent_r[TAG_IDX_W-1:0], {BLOCK_OFF_W{1'b0}}});
  assign tag_o.data = '0;
  assign tag_o.mask = '0;
  assign tag_o.v = start_i && !sent_all;

  assign done_o = sent_all && acked_all;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sent_r <= '0;
      acked_r <= '0;
    end
    else
    begin
      if (tag_o.v && tag_o.ready)
      begin
        sent_r <= sent_r + 1'b1;
      end
      // each tag store comes back as one data return
      if (ack_i && !acked_all)
      begin
        acked_r <= acked_r + 1'b1;
      end
    end
  end

endmodule

//--- logic/cmd_encode.sv
// turns a memory command header and data into a cache load or store request
module cmd_encode
  import cce_cache_pkg::*;
(
  input  mem_hdr_t    hdr_i,
  input  data_t       data_i,
  input  logic        v_i,
  cache_req_if.master req_o
);

  byte_off_t off;

  assign off = hdr_i.addr[BYTE_OFF_W-1:0];

  assign req_o.addr = hdr_i.addr[CADDR_W-1:0];
  assign req_o.v = v_i;

  // opcode by direction and size
  always_comb
  begin
    if (hdr_i.msg_type == WRITE)
    begin
      case (hdr_i.size)
        2'd0: req_o.opcode = SB;
        2'd1: req_o.opcode = SH;
        2'd2: req_o.opcode = SW;
        default: req_o.opcode = SD;
      endcase
    end
    else
    begin
      case (hdr_i.size)
        2'd0: req_o.opcode = LB;
        2'd1: req_o.opcode = LH;
        2'd2: req_o.opcode = LW;
        default: req_o.opcode = LD;
      endcase
    end
  end

  // store data repeats the low bytes so every lane holds a copy
  // mask picks the lanes at the offset, aligned down to the size
  always_comb
  begin
    case (hdr_i.size)
      2'd0:
      begin
        req_o.data = {MASK_W{data_i[BYTE_W-1:0]}};
        req_o.mask = mask_t'(1) << off;
      end
      2'd1:
      begin
        req_o.data = {(MASK_W/2){data_i[2*BYTE_W-1:0]}};
        req_o.mask = mask_t'(3) << {off[BYTE_OFF_W-1:1], 1'b0};
      end
      2'd2:
      begin
        req_o.data = {(MASK_W/4){data_i[4*BYTE_W-1:0]}};
        req_o.mask = mask_t'(15) << {off[BYTE_OFF_W-1], 2'b00};
      end
      default:
      begin
        req_o.data = data_i;
        req_o.mask = '1;
      end
    endcase
  end

endmodule

//--- logic/resp_hdr_fifo.sv
// small circular queue holding command headers until their cache data comes back
module resp_hdr_fifo
  import cce_cache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_hdr_t hdr_i,
  input  logic     push_i,
  output logic     ready_o,
  output mem_hdr_t hdr_o,
  output logic     v_o,
  input  logic     pop_i
);

  mem_hdr_t  mem_r [RESP_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_r;
  fifo_ptr_t rd_ptr_r;
  fifo_cnt_t cnt_r;
  logic      push_ok;
  logic      pop_ok;

  assign ready_o = (cnt_r != fifo_cnt_t'(RESP_FIFO_DEPTH));
  assign v_o = (cnt_r != '0);
  assign hdr_o = mem_r[rd_ptr_r];

  assign push_ok = push_i && ready_o;
  assign pop_ok = pop_i && v_o;

  always_ff @(posedge clk_i)
  begin
    if (push_ok)
    begin
      mem_r[wr_ptr_r] <= hdr_i;
    end
  end

  // pointers wrap naturally at the power of two depth
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop_ok)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push_ok && !pop_ok)
        cnt_r <= cnt_r + 1'b1;
      else if (pop_ok && !push_ok)
        cnt_r <= cnt_r - 1'b1;
    end
  end

endmodule

//--- logic/resp_pack.sv
// packs cache return data into the response word by repeating the low size bytes
module resp_pack
  import cce_cache_pkg::*;
(
  input  data_t     data_i,
  input  msg_size_t size_i,
  output data_t     data_o
);

  byte_off_t lane_mask;

  // lanes at or above the access size fold back onto the low bytes
  assign lane_mask = byte_off_t'((1 << size_i) - 1);

  always_comb
  begin
    for (int i = 0; i < MASK_W; i++)
    begin
      byte_off_t src;
      src = byte_off_t'(i) & lane_mask;
      data_o[i*BYTE_W +: BYTE_W] = data_i[src*BYTE_W +: BYTE_W];
    end
  end

endmodule

//--- logic/cache_cmd_ctrl.sv
// bridge FSM: clears tags after reset, then forwards commands to the cache port
module cache_cmd_ctrl
  import cce_cache_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  cache_req_if.slave    tag_i,
  cache_req_if.slave    cmd_i,
  input  logic          tag_done_i,
  output logic          tag_start_o,
  output logic          ack_o,
  input  logic          fifo_ready_i,
  output logic          push_o,
  output cache_opcode_e cache_opcode_o,
  output caddr_t        cache_addr_o,
  output data_t         cache_data_o,
  output mask_t         cache_mask_o,
  output logic          cache_v_o,
  input  logic          cache_ready_i,
  input  logic          cache_v_i,
  input  logic          resp_fire_i,
  output logic          cache_yumi_o
);

  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    READY
  } ctrl_state_e;

  ctrl_state_e state_r;
  ctrl_state_e state_n;

  assign tag_start_o = (state_r == CLEAR_TAG);

  always_comb
  begin
    state_n = state_r;
    cache_opcode_o = cmd_i.opcode;
    cache_addr_o = cmd_i.addr;
    cache_data_o = cmd_i.data;
    cache_mask_o = cmd_i.mask;
    cache_v_o = 1'b0;
    tag_i.ready = 1'b0;
    cmd_i.ready = 1'b0;
    push_o = 1'b0;
    ack_o = 1'b0;
    cache_yumi_o = 1'b0;

    case (state_r)
      RESET:
      begin
        state_n = CLEAR_TAG;
      end
      CLEAR_TAG:
      begin
        cache_opcode_o = tag_i.opcode;
        cache_addr_o = tag_i.addr;
        cache_data_o = tag_i.data;
        cache_mask_o = tag_i.mask;
        cache_v_o = tag_i.v;
        tag_i.ready = cache_ready_i;
        // tag store returns carry no payload, take them all
        ack_o = cache_v_i;
        cache_yumi_o = cache_v_i;
        if (tag_done_i)
          state_n = READY;
      end
      READY:
      begin
        // hold off commands when no header slot is free
        cache_v_o = cmd_i.v && fifo_ready_i;
        cmd_i.ready = cache_ready_i && fifo_ready_i;
        push_o = cache_v_o && cache_ready_i;
        cache_yumi_o = resp_fire_i;
      end
      default:
      begin
        state_n = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= RESET;
    else
      state_r <= state_n;
  end

endmodule

//--- logic/cce_to_cache.sv
// top of the memory command to cache bridge, connects the tag clear, encode and response units
module cce_to_cache
  import cce_cache_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,

  // memory command
  input  msg_type_e     mem_cmd_type_i,
  input  msg_size_t     mem_cmd_size_i,
  input  paddr_t        mem_cmd_addr_i,
  input  data_t         mem_cmd_data_i,
  input  logic          mem_cmd_v_i,
  output logic          mem_cmd_ready_o,

  // cache packet
  output cache_opcode_e cache_opcode_o,
  output caddr_t        cache_addr_o,
  output data_t         cache_data_o,
  output mask_t         cache_mask_o,
  output logic          cache_v_o,
  input  logic          cache_ready_i,

  // cache data return
  input  data_t         cache_data_i,
  input  logic          cache_v_i,
  output logic          cache_yumi_o,

  // memory response
  output msg_type_e     mem_resp_type_o,
  output msg_size_t     mem_resp_size_o,
  output paddr_t        mem_resp_addr_o,
  output data_t         mem_resp_data_o,
  output logic          mem_resp_v_o,
  input  logic          mem_resp_ready_i
);

  mem_hdr_t cmd_hdr;
  mem_hdr_t resp_hdr;
  logic     resp_hdr_v;
  logic     resp_fire;
  logic     fifo_ready;
  logic     fifo_push;
  logic     tag_start;
  logic     tag_ack;
  logic     tag_done;

  cache_req_if tag_req ();
  cache_req_if cmd_req ();

  assign cmd_hdr = '{msg_type: mem_cmd_type_i, size: mem_cmd_size_i, addr: mem_cmd_addr_i};
  assign mem_cmd_ready_o = cmd_req.ready;

  // response only when a header waits and the cache has data
  assign mem_resp_v_o = resp_hdr_v && cache_v_i;
  assign resp_fire = mem_resp_v_o && mem_resp_ready_i;
  assign mem_resp_type_o = resp_hdr.msg_type;
  assign mem_resp_size_o = resp_hdr.size;
  assign mem_resp_addr_o = resp_hdr.addr;

  cache_tag_init tag_init (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (tag_start),
    .ack_i   (tag_ack),
    .tag_o   (tag_req),
    .done_o  (tag_done)
  );

  cmd_encode encode (
    .hdr_i  (cmd_hdr),
    .data_i (mem_cmd_data_i),
    .v_i    (mem_cmd_v_i),
    .req_o  (cmd_req)
  );

  cache_cmd_ctrl ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .tag_i          (tag_req),
    .cmd_i          (cmd_req),
    .tag_done_i     (tag_done),
    .tag_start_o    (tag_start),
    .ack_o          (tag_ack),
    .fifo_ready_i   (fifo_ready),
    .push_o         (fifo_push),
    .cache_opcode_o (cache_opcode_o),
    .cache_addr_o   (cache_addr_o),
    .cache_data_o   (cache_data_o),
    .cache_mask_o   (cache_mask_o),
    .cache_v_o      (cache_v_o),
    .cache_ready_i  (cache_ready_i),
    .cache_v_i      (cache_v_i),
    .resp_fire_i    (resp_fire),
    .cache_yumi_o   (cache_yumi_o)
  );

  resp_hdr_fifo hdr_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .hdr_i   (cmd_hdr),
    .push_i  (fifo_push),
    .ready_o (fifo_ready),
    .hdr_o   (resp_hdr),
    .v_o     (resp_hdr_v),
    .pop_i   (resp_fire)
  );

  resp_pack pack (
    .data_i (cache_data_i),
    .size_i (resp_hdr.size),
    .data_o (mem_resp_data_o)
  );

endmodule

//--- tb/cache_model.sv
// behavioral blocking cache with random stalls and return delays for the bridge testbench
module cache_model
  import cce_cache_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  cache_opcode_e opcode_i,
  input  caddr_t        addr_i,
  input  data_t         data_i,
  input  mask_t         mask_i,
  input  logic          v_i,
  output logic          ready_o,
  output data_t         data_o,
  output logic          v_o,
  input  logic          yumi_i
);
  timeunit 1ns;
  timeprecision 100ps;

  data_t  mem [64];
  data_t  ret_q [$];
  int     due_q [$];
  int     cycle;
  int     tag_cnt;
  int     acc_cnt;
  int     ret_cnt;
  caddr_t tag_addr [64];

  initial
  begin
    for (int i = 0; i < 64; i++)
      mem[i] = '0;
    cycle = 0;
    tag_cnt = 0;
    acc_cnt = 0;
    ret_cnt = 0;
    ready_o = 1'b0;
    data_o = '0;
    v_o = 1'b0;
  end

  // packets are taken and returns retired on the rising edge
  always @(posedge clk_i)
  begin
    int idx;
    cycle++;
    if (!reset_i)
    begin
      if (v_o && yumi_i)
      begin
        void'(ret_q.pop_front());
        void'(due_q.pop_front());
        ret_cnt++;
      end
      if (v_i && ready_o)
      begin
        idx = int'(addr_i[8:3]);
        acc_cnt++;
        due_q.push_back(cycle + int'($urandom_range(0, 4)));
        case (opcode_i)
          TAGST:
          begin
            if (tag_cnt < 64)
              tag_addr[tag_cnt] = addr_i;
            tag_cnt++;
            ret_q.push_back('0);
          end
          SB, SH, SW, SD:
          begin
            for (int b = 0; b < MASK_W; b++)
              if (mask_i[b])
                mem[idx][b*8 +: 8] = data_i[b*8 +: 8];
            ret_q.push_back('0);
          end
          default:
            ret_q.push_back(mem[idx]);
        endcase
      end
    end
  end

  // head of the queue is offered once its delay has run out
  always @(negedge clk_i)
  begin
    ready_o = !reset_i && ($urandom_range(0, 3) != 0);
    if (!reset_i && ret_q.size() > 0 && cycle >= due_q[0])
    begin
      v_o = 1'b1;
      data_o = ret_q[0];
    end
    else
    begin
      v_o = 1'b0;
      data_o = '0;
    end
  end

endmodule

//--- tb/cce_to_cache_tb.sv
// testbench for the bridge that checks the tag clear, command encoding and ordered responses
module cce_to_cache_tb
  import cce_cache_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic          clk_i;
  logic          reset_i;
  msg_type_e     mem_cmd_type_i;
  msg_size_t     mem_cmd_size_i;
  paddr_t        mem_cmd_addr_i;
  data_t         mem_cmd_data_i;
  logic          mem_cmd_v_i;
  logic          mem_cmd_ready_o;
  cache_opcode_e cache_opcode_o;
  caddr_t        cache_addr_o;
  data_t         cache_data_o;
  mask_t         cache_mask_o;
  logic          cache_v_o;
  logic          cache_ready_i;
  data_t         cache_data_i;
  logic          cache_v_i;
  logic          cache_yumi_o;
  msg_type_e     mem_resp_type_o;
  msg_size_t     mem_resp_size_o;
  paddr_t        mem_resp_addr_o;
  data_t         mem_resp_data_o;
  logic          mem_resp_v_o;
  logic          mem_resp_ready_i;

  int       errors;
  int       n_cmd;
  int       n_resp;
  logic     resp_bp;
  logic     timed_out;
  data_t    shadow [64];
  mem_hdr_t exp_hdr_q [$];
  data_t    exp_data_q [$];

  cce_to_cache dut (.*);

  cache_model model (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .opcode_i (cache_opcode_o),
    .addr_i   (cache_addr_o),
    .data_i   (cache_data_o),
    .mask_i   (cache_mask_o),
    .v_i      (cache_v_o),
    .ready_o  (cache_ready_i),
    .data_o   (cache_data_i),
    .v_o      (cache_v_i),
    .yumi_i   (cache_yumi_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic cache_opcode_e opcode_for(msg_type_e t, msg_size_t s);
    cache_opcode_e ld [4];
    cache_opcode_e st [4];
    ld = '{LB, LH, LW, LD};
    st = '{SB, SH, SW, SD};
    return (t == WRITE) ? st[s] : ld[s];
  endfunction

  // ones on the accessed bytes from the offset aligned down to the size
  function automatic mask_t mask_for(msg_size_t s, paddr_t a);
    int    nbytes;
    int    start;
    mask_t m;
    nbytes = 1 << s;
    start = (int'(a[2:0]) / nbytes) * nbytes;
    m = '0;
    for (int i = 0; i < nbytes; i++)
      m[start + i] = 1'b1;
    return m;
  endfunction

  function automatic data_t replicate_low(data_t d, msg_size_t s);
    int    nbytes;
    data_t r;
    nbytes = 1 << s;
    for (int i = 0; i < MASK_W; i++)
      r[i*8 +: 8] = d[(i % nbytes)*8 +: 8];
    return r;
  endfunction

  // stores answer with zero and loads with the low bytes of the stored word
  function automatic data_t expect_resp(msg_type_e t, msg_size_t s, paddr_t a);
    if (t == WRITE)
      return '0;
    return replicate_low(shadow[a[8:3]], s);
  endfunction

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_run();
    $display("commands %0d responses %0d errors %0d", n_cmd, n_resp, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  endtask

  task automatic send_cmd(msg_type_e t, msg_size_t s, paddr_t a, data_t d);
    int       tries;
    mask_t    m;
    data_t    rd;
    mem_hdr_t h;
    if (timed_out)
      return;
    @(negedge clk_i);
    mem_cmd_type_i = t;
    mem_cmd_size_i = s;
    mem_cmd_addr_i = a;
    mem_cmd_data_i = d;
    mem_cmd_v_i = 1'b1;
    tries = 0;
    do
    begin
      @(posedge clk_i);
      tries++;
    end
    while (!mem_cmd_ready_o && tries < 200);
    if (!mem_cmd_ready_o)
    begin
      $display("command to address %h was never accepted", a);
      errors++;
      timed_out = 1'b1;
    end
    else
    begin
      m = mask_for(s, a);
      rd = replicate_low(d, s);
      check_val("cache_v_o", 64'(cache_v_o), 64'd1);
      check_val("cache_opcode_o", 64'(cache_opcode_o), 64'(opcode_for(t, s)));
      check_val("cache_addr_o", 64'(cache_addr_o), 64'(a[CADDR_W-1:0]));
      check_val("cache_mask_o", 64'(cache_mask_o), 64'(m));
      check_val("cache_data_o", cache_data_o, rd);
      h = '{msg_type: t, size: s, addr: a};
      exp_hdr_q.push_back(h);
      exp_data_q.push_back(expect_resp(t, s, a));
      if (t == WRITE)
        for (int b = 0; b < MASK_W; b++)
          if (m[b])
            shadow[a[8:3]][b*8 +: 8] = rd[b*8 +: 8];
      n_cmd++;
    end
  endtask

  task automatic drain();
    int tries;
    if (timed_out)
      return;
    @(negedge clk_i);
    mem_cmd_v_i = 1'b0;
    tries = 0;
    while (exp_hdr_q.size() > 0 && tries < 1000)
    begin
      @(posedge clk_i);
      tries++;
    end
    if (exp_hdr_q.size() > 0)
    begin
      $display("%0d responses never arrived", exp_hdr_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // response back-pressure is random only in the stress phase
  always @(negedge clk_i)
    mem_resp_ready_i = resp_bp ? ($urandom_range(0, 2) != 0) : 1'b1;

  always @(posedge clk_i)
  begin
    mem_hdr_t h;
    data_t    d;
    if (!reset_i)
    begin
      if (cache_yumi_o && !cache_v_i)
      begin
        $display("cache_yumi_o was raised while cache_v_i was low");
        errors++;
      end
      if (mem_resp_v_o && mem_resp_ready_i)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          $display("a response arrived with no command outstanding");
          errors++;
        end
        else
        begin
          h = exp_hdr_q.pop_front();
          d = exp_data_q.pop_front();
          check_val("mem_resp_type_o", 64'(mem_resp_type_o), 64'(h.msg_type));
          check_val("mem_resp_size_o", 64'(mem_resp_size_o), 64'(h.size));
          check_val("mem_resp_addr_o", 64'(mem_resp_addr_o), 64'(h.addr));
          check_val("mem_resp_data_o", mem_resp_data_o, d);
          n_resp++;
        end
      end
    end
  end

  initial
  begin
    int     tries;
    paddr_t a;
    void'($urandom(88360));
    errors = 0;
    n_cmd = 0;
    n_resp = 0;
    resp_bp = 1'b0;
    timed_out = 1'b0;
    for (int i = 0; i < 64; i++)
      shadow[i] = '0;
    reset_i = 1'b1;
    mem_cmd_type_i = READ;
    mem_cmd_size_i = '0;
    mem_cmd_addr_i = '0;
    mem_cmd_data_i = '0;
    mem_cmd_v_i = 1'b0;
    mem_resp_ready_i = 1'b1;
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;

    // command port opens only after every tag store has come back
    tries = 0;
    do
    begin
      @(posedge clk_i);
      tries++;
    end
    while (!mem_cmd_ready_o && tries < 1000);
    if (!mem_cmd_ready_o)
    begin
      $display("mem_cmd_ready_o never rose after the tag clear");
      errors++;
      timed_out = 1'b1;
    end
    else
    begin
      check_val("tag store count", 64'(model.tag_cnt), 64'd32);
      check_val("tag returns taken", 64'(model.ret_cnt), 64'd32);
      for (int i = 0; i < 32; i++)
        check_val("tag store addr", 64'(model.tag_addr[i]), 64'(i * 64));
    end

    // each size at each aligned offset followed by a read of the merged word
    for (int s = 0; s < 4; s++)
      for (int off = 0; off < 8; off += (1 << s))
      begin
        a = ($urandom() & 32'hffff_fe00) | paddr_t'(off * 8 + off);
        send_cmd(WRITE, msg_size_t'(s), a, {$urandom(), $urandom()});
        send_cmd(READ, 2'd3, a & ~32'h7, '0);
      end
    for (int s = 0; s < 3; s++)
      for (int i = 0; i < 4; i++)
        send_cmd(READ, msg_size_t'(s), $urandom() & 32'hffff_fe3f, '0);
    drain();

    resp_bp = 1'b1;
    for (int i = 0; i < 40; i++)
      send_cmd($urandom_range(0, 1) ? WRITE : READ, msg_size_t'($urandom_range(0, 3)),
               $urandom() & 32'hffff_fe7f, {$urandom(), $urandom()});
    drain();

    // no packet beyond the tag stores and the commands reached the cache
    if (!timed_out)
    begin
      @(negedge clk_i);
      check_val("cache packets taken", 64'(model.acc_cnt), 64'(n_cmd + 32));
      check_val("cache returns taken", 64'(model.ret_cnt), 64'(n_cmd + 32));
      check_val("tag store count", 64'(model.tag_cnt), 64'd32);
    end
    end_run();
  end

endmodule

//--- src.f
logic/cce_cache_pkg.sv
logic/cache_req_if.sv
logic/cache_tag_init.sv
logic/cmd_encode.sv
logic/resp_hdr_fifo.sv
logic/resp_pack.sv
logic/cache_cmd_ctrl.sv
logic/cce_to_cache.sv
tb/cache_model.sv
tb/cce_to_cache_tb.sv

//--- Makefile
TOP = cce_to_cache_tb

all: run

compile:
	verilator --binary --timing -sv -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
